// ==== dv/dcache_golden.txt ====
# op addr wdata strb expected_data l2_reads l2_writes (hex except the two counts)
# R read, W write, F flush, M check of the word stored in the L2 model
R 00001040 00000000 0 5a5a1040 1 0
R 00001048 00000000 0 5a5a1048 1 0
W 00001044 deadbeef 5 00000000 1 0
R 00001044 00000000 0 5aad10ef 1 0
R 00001444 00000000 0 5a5a1444 2 1
M 00001044 00000000 0 5aad10ef 2 1
M 00001040 00000000 0 5a5a1040 2 1
R 00001044 00000000 0 5aad10ef 3 1
R 00002080 00000000 0 5a5a2080 4 1
R 00002480 00000000 0 5a5a2480 5 1
W 00003000 11223344 f 00000000 6 1
W 000030c8 cafef00d c 00000000 7 1
W 00001040 01020304 3 00000000 7 1
R 00001040 00000000 0 5a5a0304 7 1
F 00000000 00000000 0 00000000 7 4
M 00003000 00000000 0 11223344 7 4
M 000030c8 00000000 0 cafe30c8 7 4
M 000030cc 00000000 0 5a5a30cc 7 4
M 00001040 00000000 0 5a5a0304 7 4
R 00003000 00000000 0 11223344 8 4
R 000030c8 00000000 0 cafe30c8 9 4
R 00001040 00000000 0 5a5a0304 10 4
R 00002480 00000000 0 5a5a2480 11 4
F 00000000 00000000 0 00000000 11 4
R 00002484 00000000 0 5a5a2484 12 4

// ==== dv/l2_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_model (
    input  logic                                       CLK,
    input  logic                                       RST,
    input  logic                                       l2_rd_req,
    input  logic [cache_geom_pkg::LINE_ADDR_WIDTH-1:0] l2_rd_addr,
    output logic                                       l2_rd_valid,
    output logic [cache_geom_pkg::LINE_WIDTH-1:0]      l2_rd_data,
    input  logic                                       l2_wr_valid,
    input  logic [cache_geom_pkg::LINE_ADDR_WIDTH-1:0] l2_wr_addr,
    input  logic [cache_geom_pkg::LINE_WIDTH-1:0]      l2_wr_data,
    output logic                                       l2_wr_done,
    output int                                         rd_count,
    output int                                         wr_count
);
    import cache_geom_pkg::*;

    localparam logic [31:0] SEED     = 32'hfe09_74a6;
    localparam logic [31:0] FILL_KEY = 32'h5a5a_0000;

    logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];  // Only written words are stored
    logic [31:0]           rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] word_address(
        input logic [LINE_ADDR_WIDTH-1:0] line_addr,
        input int                         word
    );
        return {line_addr, {OFFSET_WIDTH{1'b0}}} + ADDR_WIDTH'(word * STRB_WIDTH);
    endfunction

    // Unwritten words read back as a pattern of their own byte address
    function automatic logic [DATA_WIDTH-1:0] peek_word(input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] word_addr;
        word_addr = {addr[ADDR_WIDTH-1:BYTE_SEL_WIDTH], {BYTE_SEL_WIDTH{1'b0}}};
        if (mem.exists(word_addr)) begin
            return mem[word_addr];
        end
        return word_addr ^ FILL_KEY;
    endfunction

    initial begin
        int                         delay;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        l2_rd_valid = 1'b0;
        l2_rd_data  = '0;
        l2_wr_done  = 1'b0;
        rd_count    = 0;
        wr_count    = 0;
        rng         = SEED;
        forever begin
            @(negedge CLK);
            l2_rd_valid = 1'b0;
            l2_wr_done  = 1'b0;
            if (!RST && l2_rd_req === 1'b1) begin
                line_addr = l2_rd_addr;
                rd_count++;
                rng   = xorshift32(rng);
                delay = int'(rng[2:0]) + 1;
                repeat (delay) @(negedge CLK);
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    l2_rd_data[w * DATA_WIDTH +: DATA_WIDTH] = peek_word(word_address(line_addr, w));
                end
                l2_rd_valid = 1'b1;
            end else if (!RST && l2_wr_valid === 1'b1) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[word_address(l2_wr_addr, w)] = l2_wr_data[w * DATA_WIDTH +: DATA_WIDTH];
                end
                wr_count++;
                rng   = xorshift32(rng);
                delay = int'(rng[2:0]) + 1;
                repeat (delay) @(negedge CLK);
                l2_wr_done = 1'b1;  // The pulse is dropped at the next falling edge
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import cache_geom_pkg::*;

    localparam string GOLDEN_FILE  = "dv/dcache_golden.txt";
    localparam int    ACCESS_LIMIT = 100;   // A dirty miss takes two L2 round trips
    localparam int    FLUSH_LIMIT  = 2000;

    logic                       CLK;
    logic                       RST;
    logic                       req_valid;
    logic                       req_write;
    logic [ADDR_WIDTH-1:0]      req_addr;
    logic [DATA_WIDTH-1:0]      req_wdata;
    logic [STRB_WIDTH-1:0]      req_wstrb;
    logic                       flush;
    logic                       ready;
    logic                       rsp_valid;
    logic [DATA_WIDTH-1:0]      rdata;
    logic                       l2_rd_req;
    logic [LINE_ADDR_WIDTH-1:0] l2_rd_addr;
    logic                       l2_rd_valid;
    logic [LINE_WIDTH-1:0]      l2_rd_data;
    logic                       l2_wr_valid;
    logic [LINE_ADDR_WIDTH-1:0] l2_wr_addr;
    logic [LINE_WIDTH-1:0]      l2_wr_data;
    logic                       l2_wr_done;
    int                         rd_count;
    int                         wr_count;

    dcache_top i_dut (
        .CLK(CLK), .RST(RST),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb), .flush(flush),
        .ready(ready), .rsp_valid(rsp_valid), .rdata(rdata),
        .l2_rd_req(l2_rd_req), .l2_rd_addr(l2_rd_addr), .l2_rd_valid(l2_rd_valid),
        .l2_rd_data(l2_rd_data), .l2_wr_valid(l2_wr_valid), .l2_wr_addr(l2_wr_addr),
        .l2_wr_data(l2_wr_data), .l2_wr_done(l2_wr_done)
    );

    l2_model i_l2 (
        .CLK(CLK), .RST(RST),
        .l2_rd_req(l2_rd_req), .l2_rd_addr(l2_rd_addr), .l2_rd_valid(l2_rd_valid),
        .l2_rd_data(l2_rd_data), .l2_wr_valid(l2_wr_valid), .l2_wr_addr(l2_wr_addr),
        .l2_wr_data(l2_wr_data), .l2_wr_done(l2_wr_done),
        .rd_count(rd_count), .wr_count(wr_count)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("Finished with errors");
        $fatal(1, "%s", reason);
    endtask

    // Called on a falling edge with ready high, so the request is taken at the next rising edge
    task automatic run_access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata,
                              input logic [STRB_WIDTH-1:0] strb,
                              output logic [DATA_WIDTH-1:0] data, output int latency);
        check_value({31'd0, ready}, 32'd1, "ready before a request");
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        req_valid = 1'b1;
        @(negedge CLK);
        req_valid = 1'b0;  // Address, data and strobes stay put until the response
        check_value({31'd0, ready}, 32'd0, "ready after accept");
        latency = 1;
        while (rsp_valid !== 1'b1) begin
            if (latency >= ACCESS_LIMIT) begin
                stop_with_failure("Timed out waiting for rsp_valid");
            end else begin
                @(negedge CLK);
                latency++;
            end
        end
        check_value({31'd0, ready}, 32'd1, "ready with the response");
        data = rdata;
    endtask

    task automatic run_flush();
        int cycles;
        check_value({31'd0, ready}, 32'd1, "ready before a flush");
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        check_value({31'd0, ready}, 32'd0, "ready after flush accept");
        cycles = 0;
        while (ready !== 1'b1) begin
            check_value({31'd0, rsp_valid}, 32'd0, "rsp_valid during flush");
            if (cycles >= FLUSH_LIMIT) begin
                stop_with_failure("Timed out waiting for the flush to finish");
            end else begin
                @(negedge CLK);
                cycles++;
            end
        end
    endtask

    initial begin
        int                    fd;
        int                    fields;
        int                    line_no;
        int                    exp_rd;
        int                    exp_wr;
        int                    prev_rd;
        int                    prev_wr;
        int                    latency;
        string                 text;
        logic [7:0]            op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [DATA_WIDTH-1:0] got;
        logic [STRB_WIDTH-1:0] strb;
        RST       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        flush     = 1'b0;
        repeat (16) @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);
        check_value({31'd0, ready}, 32'd1, "ready after reset");
        check_value({31'd0, rsp_valid}, 32'd0, "rsp_valid after reset");
        check_value({31'd0, l2_rd_req}, 32'd0, "l2_rd_req after reset");
        check_value({31'd0, l2_wr_valid}, 32'd0, "l2_wr_valid after reset");
        check_value(32'(rd_count), 32'd0, "L2 read count after reset");
        check_value(32'(wr_count), 32'd0, "L2 write count after reset");

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the golden file");
        end
        line_no = 0;
        prev_rd = 0;
        prev_wr = 0;
        while ($fgets(text, fd) != 0) begin
            line_no++;
            if (text.len() >= 2 && text.getc(0) != "#") begin
                fields = $sscanf(text, "%c %h %h %h %h %d %d",
                                 op, addr, wdata, strb, exp_data, exp_rd, exp_wr);
                if (fields != 7) begin
                    stop_with_failure($sformatf("Golden line %0d is malformed", line_no));
                end
                case (op)
                    "R", "W": begin
                        run_access(op == "W", addr, wdata, strb, got, latency);
                        if (op == "R") begin
                            check_value(got, exp_data, $sformatf("rdata, golden line %0d", line_no));
                        end
                        // No new L2 traffic means a hit
                        if (exp_rd == prev_rd && exp_wr == prev_wr) begin
                            check_value(32'(latency), 32'd2,
                                        $sformatf("hit latency, golden line %0d", line_no));
                        end
                    end
                    "F": run_flush();
                    "M": check_value(i_l2.peek_word(addr), exp_data,
                                     $sformatf("L2 word, golden line %0d", line_no));
                    default: stop_with_failure($sformatf("Unknown operation on golden line %0d",
                                                         line_no));
                endcase
                check_value(32'(rd_count), 32'(exp_rd),
                            $sformatf("L2 read count, golden line %0d", line_no));
                check_value(32'(wr_count), 32'(exp_wr),
                            $sformatf("L2 write count, golden line %0d", line_no));
                prev_rd = exp_rd;
                prev_wr = exp_wr;
            end
        end
        $fclose(fd);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl_fsm (
    input  logic                                       CLK,
    input  logic                                       RST,
    input  logic                                       req_valid,
    input  logic                                       req_write,
    input  cache_geom_pkg::cache_addr_u                req_addr,
    input  logic                                       flush,
    input  logic [cache_geom_pkg::TAG_WIDTH-1:0]       tag_rd,
    input  logic                                       valid_rd,
    input  logic                                       dirty_rd,
    input  logic                                       l2_rd_valid,
    input  logic                                       l2_wr_done,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0]     flush_index,
    input  logic                                       flush_last,
    output logic                                       ready,
    output logic                                       rsp_valid,
    output logic [cache_geom_pkg::INDEX_WIDTH-1:0]     store_index,
    output logic                                       line_wr_en,
    output logic                                       line_wr_sel_refill,
    output logic                                       tag_wr_en,
    output logic                                       valid_wr,
    output logic                                       dirty_wr,
    output logic [cache_geom_pkg::WORD_SEL_WIDTH-1:0]  wr_word_sel,
    output logic                                       l2_rd_req,
    output logic                                       l2_wr_valid,
    output logic [cache_geom_pkg::LINE_ADDR_WIDTH-1:0] l2_line_addr,
    output logic                                       cnt_load,
    output logic                                       cnt_step,
    output logic                                       hold_write
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    cache_addr_u req_q;
    logic        write_q;
    logic        flush_q;  // Write-back belongs to the flush walk
    logic        hit;
    logic        victim_dirty;

    assign hit          = valid_rd && (tag_rd == req_q.f.tag);
    assign victim_dirty = valid_rd && dirty_rd;
    assign ready        = (state == ST_IDLE);
    assign l2_rd_req    = (state == ST_RF_ISSUE);
    assign l2_wr_valid  = (state == ST_WB_ISSUE);
    assign wr_word_sel  = req_q.f.word_sel;
    assign hold_write   = write_q;

    // The stores see the index one cycle before its data is needed
    always_comb begin
        case (state)
            ST_IDLE:                       store_index = req_addr.f.index;
            ST_FLUSH_READ, ST_FLUSH_CHECK: store_index = flush_index;
            default:                       store_index = flush_q ? flush_index : req_q.f.index;
        endcase
    end

    always_comb begin
        state_nxt          = state;
        line_wr_en         = 1'b0;
        line_wr_sel_refill = 1'b0;
        tag_wr_en          = 1'b0;
        valid_wr           = 1'b0;
        dirty_wr           = 1'b0;
        cnt_load           = 1'b0;
        cnt_step           = 1'b0;
        case (state)
            ST_IDLE: begin
                if (flush) begin
                    cnt_load  = 1'b1;
                    state_nxt = ST_FLUSH_READ;
                end else if (req_valid) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    line_wr_en = write_q;
                    tag_wr_en  = write_q;
                    valid_wr   = 1'b1;
                    dirty_wr   = 1'b1;
                    state_nxt  = ST_IDLE;
                end else begin
                    state_nxt = victim_dirty ? ST_WB_ISSUE : ST_RF_ISSUE;
                end
            end
            ST_WB_ISSUE: state_nxt = ST_WB_WAIT;
            ST_WB_WAIT: begin
                if (l2_wr_done) begin
                    if (!flush_q) begin
                        state_nxt = ST_RF_ISSUE;
                    end else if (flush_last) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        cnt_step  = 1'b1;
                        state_nxt = ST_FLUSH_READ;
                    end
                end
            end
            ST_RF_ISSUE: state_nxt = ST_RF_WAIT;
            ST_RF_WAIT: begin
                if (l2_rd_valid) begin
                    line_wr_en         = 1'b1;
                    line_wr_sel_refill = 1'b1;
                    tag_wr_en          = 1'b1;
                    valid_wr           = 1'b1;
                    state_nxt          = ST_LOOKUP;  // Looks again and now hits
                end
            end
            ST_FLUSH_READ: state_nxt = ST_FLUSH_CHECK;
            ST_FLUSH_CHECK: begin
                tag_wr_en = 1'b1;  // Every walked line ends up invalid and clean
                if (victim_dirty) begin
                    state_nxt = ST_WB_ISSUE;
                end else if (flush_last) begin
                    state_nxt = ST_IDLE;
                end else begin
                    cnt_step  = 1'b1;
                    state_nxt = ST_FLUSH_READ;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
            flush_q   <= 1'b0;
        end else begin
            state     <= state_nxt;
            rsp_valid <= (state == ST_LOOKUP) && hit;
            if (cnt_load) begin
                flush_q <= 1'b1;
            end else if (state_nxt == ST_IDLE) begin
                flush_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && req_valid && !flush) begin
            req_q        <= req_addr;
            write_q      <= req_write;
            l2_line_addr <= req_addr.raw[ADDR_WIDTH-1:OFFSET_WIDTH];
        end
        if (state == ST_LOOKUP && !hit && victim_dirty) begin
            l2_line_addr <= {tag_rd, req_q.f.index};
        end
        if (state == ST_WB_WAIT && l2_wr_done) begin
            l2_line_addr <= req_q.raw[ADDR_WIDTH-1:OFFSET_WIDTH];  // Back to the missed line
        end
        if (state == ST_FLUSH_CHECK && victim_dirty) begin
            l2_line_addr <= {tag_rd, flush_index};
        end
    end

    assert property (@(posedge CLK) disable iff (RST) !(l2_rd_req && l2_wr_valid));
    assert property (@(posedge CLK) disable iff (RST) rsp_valid |=> !rsp_valid);
    // L2 answers arrive only while the controller waits for them
    assert property (@(posedge CLK) disable iff (RST) l2_rd_valid |-> state == ST_RF_WAIT);
    assert property (@(posedge CLK) disable iff (RST) l2_wr_done |-> state == ST_WB_WAIT);

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_LOOKUP      = 3'd1,
        ST_WB_ISSUE    = 3'd2,  // Victim or flushed line goes out to L2
        ST_WB_WAIT     = 3'd3,
        ST_RF_ISSUE    = 3'd4,
        ST_RF_WAIT     = 3'd5,
        ST_FLUSH_READ  = 3'd6,
        ST_FLUSH_CHECK = 3'd7
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;
    localparam int WORDS_PER_LINE  = 4;
    localparam int NUM_LINES       = 64;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;
    localparam int LINE_WIDTH      = DATA_WIDTH * WORDS_PER_LINE;
    localparam int WORD_SEL_WIDTH  = $clog2(WORDS_PER_LINE);
    localparam int BYTE_SEL_WIDTH  = $clog2(STRB_WIDTH);
    localparam int OFFSET_WIDTH    = WORD_SEL_WIDTH + BYTE_SEL_WIDTH;
    localparam int INDEX_WIDTH     = $clog2(NUM_LINES);
    localparam int TAG_WIDTH       = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;  // Tag and index, as seen by L2

    typedef struct packed {
        logic [TAG_WIDTH-1:0]      tag;
        logic [INDEX_WIDTH-1:0]    index;
        logic [WORD_SEL_WIDTH-1:0] word_sel;
        logic [BYTE_SEL_WIDTH-1:0] byte_sel;
    } cache_addr_s;

    // One byte address, either whole or split into its cache fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        cache_addr_s           f;
    } cache_addr_u;

endpackage

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                                       CLK,
    input  logic                                       RST,
    input  logic                                       req_valid,
    input  logic                                       req_write,
    input  logic [cache_geom_pkg::ADDR_WIDTH-1:0]      req_addr,
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0]      req_wdata,
    input  logic [cache_geom_pkg::STRB_WIDTH-1:0]      req_wstrb,
    input  logic                                       flush,
    output logic                                       ready,
    output logic                                       rsp_valid,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0]      rdata,
    output logic                                       l2_rd_req,
    output logic [cache_geom_pkg::LINE_ADDR_WIDTH-1:0] l2_rd_addr,
    input  logic                                       l2_rd_valid,
    input  logic [cache_geom_pkg::LINE_WIDTH-1:0]      l2_rd_data,
    output logic                                       l2_wr_valid,
    output logic [cache_geom_pkg::LINE_ADDR_WIDTH-1:0] l2_wr_addr,
    output logic [cache_geom_pkg::LINE_WIDTH-1:0]      l2_wr_data,
    input  logic                                       l2_wr_done
);
    import cache_geom_pkg::*;

    cache_addr_u               req_addr_u;
    cache_addr_u               line_addr_u;
    logic [INDEX_WIDTH-1:0]    store_index;
    logic [INDEX_WIDTH-1:0]    flush_index;
    logic                      flush_last;
    logic                      cnt_load;
    logic                      cnt_step;
    logic                      line_wr_en;
    logic                      line_wr_sel_refill;
    logic                      tag_wr_en;
    logic                      valid_wr;
    logic                      dirty_wr;
    logic                      hold_write;
    logic [WORD_SEL_WIDTH-1:0] wr_word_sel;
    logic [TAG_WIDTH-1:0]      tag_rd;
    logic                      valid_rd;
    logic                      dirty_rd;
    logic [LINE_WIDTH-1:0]     rd_line;
    logic [LINE_WIDTH-1:0]     merged_line;
    logic [STRB_WIDTH-1:0]     merge_wstrb;

    assign req_addr_u  = req_addr;
    assign line_addr_u = {l2_rd_addr, {OFFSET_WIDTH{1'b0}}};  // Tag written is that of the line in flight
    assign l2_wr_addr  = l2_rd_addr;
    assign l2_wr_data  = rd_line;
    assign merge_wstrb = hold_write ? req_wstrb : '0;  // Reads never change the line

    cache_ctrl_fsm i_fsm (
        .CLK(CLK), .RST(RST),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr_u), .flush(flush),
        .tag_rd(tag_rd), .valid_rd(valid_rd), .dirty_rd(dirty_rd),
        .l2_rd_valid(l2_rd_valid), .l2_wr_done(l2_wr_done),
        .flush_index(flush_index), .flush_last(flush_last),
        .ready(ready), .rsp_valid(rsp_valid), .store_index(store_index),
        .line_wr_en(line_wr_en), .line_wr_sel_refill(line_wr_sel_refill),
        .tag_wr_en(tag_wr_en), .valid_wr(valid_wr), .dirty_wr(dirty_wr),
        .wr_word_sel(wr_word_sel), .l2_rd_req(l2_rd_req), .l2_wr_valid(l2_wr_valid),
        .l2_line_addr(l2_rd_addr), .cnt_load(cnt_load), .cnt_step(cnt_step),
        .hold_write(hold_write)
    );

    flush_line_counter i_flush_cnt (
        .CLK(CLK), .RST(RST), .load(cnt_load), .step(cnt_step),
        .flush_index(flush_index), .last(flush_last)
    );

    line_store i_line_store (
        .CLK(CLK), .rd_index(store_index), .wr_en(line_wr_en), .wr_index(store_index),
        .wr_line(merged_line), .rd_line(rd_line)
    );

    tag_state_store i_tag_store (
        .CLK(CLK), .RST(RST), .rd_index(store_index), .wr_en(tag_wr_en),
        .wr_index(store_index), .wr_tag(line_addr_u.f.tag), .wr_valid(valid_wr),
        .wr_dirty(dirty_wr), .rd_tag(tag_rd), .rd_valid(valid_rd), .rd_dirty(dirty_rd)
    );

    word_merge i_merge (
        .line_in(rd_line), .word_sel(wr_word_sel), .wdata(req_wdata), .wstrb(merge_wstrb),
        .refill_line(l2_rd_data), .use_refill(line_wr_sel_refill),
        .rd_word(rdata), .line_out(merged_line)
    );

endmodule

`default_nettype wire

// ==== hdl/flush_line_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module flush_line_counter (
    input  logic                                   CLK,
    input  logic                                   RST,
    input  logic                                   load,
    input  logic                                   step,
    output logic [cache_geom_pkg::INDEX_WIDTH-1:0] flush_index,
    output logic                                   last
);
    import cache_geom_pkg::*;

    always_ff @(posedge CLK) begin
        if (RST) begin
            flush_index <= '0;
        end else if (load) begin
            flush_index <= '0;
        end else if (step) begin
            flush_index <= flush_index + 1'b1;
        end
    end

    assign last = (flush_index == INDEX_WIDTH'(NUM_LINES - 1));

    // The walk ends on the final line and never wraps
    assert property (@(posedge CLK) disable iff (RST) step |-> !last);

endmodule

`default_nettype wire

// ==== hdl/line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_store (
    input  logic                                   CLK,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0] rd_index,
    input  logic                                   wr_en,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0] wr_index,
    input  logic [cache_geom_pkg::LINE_WIDTH-1:0]  wr_line,
    output logic [cache_geom_pkg::LINE_WIDTH-1:0]  rd_line
);
    import cache_geom_pkg::*;

    logic [LINE_WIDTH-1:0] mem [NUM_LINES];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_index] <= wr_line;
        end
        // A line written at this edge reads back with its new contents
        if (wr_en && wr_index == rd_index) begin
            rd_line <= wr_line;
        end else begin
            rd_line <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tag_state_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module tag_state_store (
    input  logic                                   CLK,
    input  logic                                   RST,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0] rd_index,
    input  logic                                   wr_en,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0] wr_index,
    input  logic [cache_geom_pkg::TAG_WIDTH-1:0]   wr_tag,
    input  logic                                   wr_valid,
    input  logic                                   wr_dirty,
    output logic [cache_geom_pkg::TAG_WIDTH-1:0]   rd_tag,
    output logic                                   rd_valid,
    output logic                                   rd_dirty
);
    import cache_geom_pkg::*;

    logic [TAG_WIDTH-1:0] tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    logic                 bypass;

    assign bypass = wr_en && (wr_index == rd_index);  // Same-edge write wins over old state

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        rd_tag <= bypass ? wr_tag : tag_mem[rd_index];
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            rd_valid <= 1'b0;
            rd_dirty <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= wr_valid;
                dirty_q[wr_index] <= wr_dirty;
            end
            rd_valid <= bypass ? wr_valid : valid_q[rd_index];
            rd_dirty <= bypass ? wr_dirty : dirty_q[rd_index];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/word_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_merge (
    input  logic [cache_geom_pkg::LINE_WIDTH-1:0]     line_in,
    input  logic [cache_geom_pkg::WORD_SEL_WIDTH-1:0] word_sel,
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0]     wdata,
    input  logic [cache_geom_pkg::STRB_WIDTH-1:0]     wstrb,
    input  logic [cache_geom_pkg::LINE_WIDTH-1:0]     refill_line,
    input  logic                                      use_refill,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0]     rd_word,
    output logic [cache_geom_pkg::LINE_WIDTH-1:0]     line_out
);
    import cache_geom_pkg::*;

    logic [LINE_WIDTH-1:0] src_line;

    assign src_line = use_refill ? refill_line : line_in;
    assign rd_word  = src_line[word_sel * DATA_WIDTH +: DATA_WIDTH];

    // Only the strobed bytes of the addressed word take the new data
    always_comb begin
        line_out = src_line;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (wstrb[b]) begin
                line_out[word_sel * DATA_WIDTH + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/flush_line_counter.sv
hdl/line_store.sv
hdl/tag_state_store.sv
hdl/word_merge.sv
hdl/cache_ctrl_fsm.sv
hdl/dcache_top.sv
dv/l2_model.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_dcache \
    -Mdir obj_dir -o tb_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
